//--- vlog.f
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/bridge_cmd_pkg.sv
hdl/cmd_decode.sv
hdl/beat_engine.sv
hdl/read_assembler.sv
hdl/axi_lite_master.sv
verif/axi_lite_slave_model.sv
verif/tb_axi_lite_master.sv

//--- verif/tb_axi_lite_master.sv
`include "bridge_consts.svh"

module tb_axi_lite_master
    import axi_lite_pkg::*;
    import bridge_cmd_pkg::*;
;

    localparam int          CLK_PERIOD  = 100;
    localparam logic [31:0] SEED_INIT   = 32'hcc79_a37b;
    localparam int          N_TESTS     = 23;
    localparam longint      WATCHDOG_T  = longint'(N_TESTS) * (16 * 8 + `BRIDGE_AXI_TIMEOUT)
                                          * CLK_PERIOD;
    localparam int          MODE_NORMAL = 0;
    localparam int          MODE_ERR    = 1;
    localparam int          MODE_STUCK  = 2;

    logic       clk;
    logic       rst;
    cmd_t       cmd;
    logic [31:0] addr;
    byte_buf_t  wr_buf;
    logic       start;
    logic       done;
    status_t    status;
    byte_buf_t  rd_buf;
    logic [6:0] rd_count;
    axi_req_t   axi_req;
    axi_rsp_t   axi_rsp;
    logic       err_mode;
    logic       stuck_mode;
    int         addr_hs;

    integer     seed;
    logic [7:0] shadow [0:1023];   // Expected slave memory
    byte_buf_t  exp_buf;
    logic [6:0] exp_cnt;
    status_t    exp_status;
    int         exp_hs;
    bit         exp_bus;
    int         hs_before, valid_before, valid_cycles;
    int         checks, errors, test_count;
    event       cmd_checked;

    axi_lite_master dut0 (
        .clk(clk), .rst(rst), .cmd(cmd), .addr(addr), .wr_buf(wr_buf), .start(start),
        .done(done), .status(status), .rd_buf(rd_buf), .rd_count(rd_count),
        .axi_req(axi_req), .axi_rsp(axi_rsp)
    );

    axi_lite_slave_model #(.SEED(SEED_INIT)) slave0 (
        .clk(clk), .rst(rst), .err_mode(err_mode), .stuck_mode(stuck_mode),
        .axi_req(axi_req), .axi_rsp(axi_rsp), .addr_hs(addr_hs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic cmd_t make_cmd(input bit rw, input bit inc, input int size, input int len);
        cmd_t c;
        c.rw   = rw;
        c.inc  = inc;
        c.size = 2'(size);
        c.len  = 4'(len);
        return c;
    endfunction

    // Expected outcome of one command, updates the shadow memory for writes
    function automatic void predict(input cmd_t c, input logic [31:0] a, input byte_buf_t wb,
            input int mode, output byte_buf_t ebuf, output logic [6:0] ecnt,
            output status_t est, output int ehs, output bit ebus);
        int         w;
        bit         bad;
        logic [9:0] ba;
        w    = (c.size == 2'd0) ? 1 : (c.size == 2'd1) ? 2 : 4;
        bad  = (c.size == 2'd3) || (c.size == 2'd1 && a[0]) || (c.size == 2'd2 && a[1:0] != 0);
        ebuf = '0;
        ecnt = '0;
        ehs  = 0;
        ebus = !bad;   // Misaligned start never touches the bus
        if (bad) begin
            est = status_addr_align;
            return;
        end
        if (mode == MODE_STUCK) begin
            est = status_timeout;
            return;
        end
        est = (mode == MODE_ERR) ? status_slverr : status_ok;
        ehs = c.len + 1;
        for (int k = 0; k <= c.len; k++) begin
            ba = c.inc ? 10'(a + k * w) : 10'(a);
            for (int j = 0; j < w; j++) begin
                if (c.rw) ebuf[k*w + j] = shadow[ba + j];
                else shadow[ba + j] = wb[k*w + j];
            end
        end
        if (c.rw) ecnt = 7'((c.len + 1) * w);
    endfunction

    task automatic check_value(input string name, input logic [511:0] expected,
                               input logic [511:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    // Comparing process, samples at the falling edge
    initial begin
        valid_cycles = 0;
        forever begin
            @(negedge clk);
            if (axi_req.awvalid || axi_req.wvalid || axi_req.bready ||
                axi_req.arvalid || axi_req.rready) valid_cycles++;
            if (done) begin
                check_value("status", exp_status, status);
                check_value("rd_count", exp_cnt, rd_count);
                check_value("rd_buf", exp_buf, rd_buf);
                check_value("addr_handshakes", exp_hs, addr_hs - hs_before);
                check_value("bus_valid_seen", exp_bus, valid_cycles != valid_before);
                for (int i = 0; i < 1024; i++) begin
                    check_value($sformatf("mem[%0d]", i), shadow[i], slave0.mem[i]);
                end
                ->cmd_checked;
            end
        end
    end

    task automatic run_cmd(input string name, input cmd_t c, input logic [31:0] a,
                           input int mode);
        byte_buf_t wb;
        int        errors_before;
        for (int i = 0; i < 64; i++) wb[i] = 8'($random(seed));
        predict(c, a, wb, mode, exp_buf, exp_cnt, exp_status, exp_hs, exp_bus);
        errors_before = errors;
        @(posedge clk);
        #10;
        err_mode     = (mode == MODE_ERR);
        stuck_mode   = (mode == MODE_STUCK);
        cmd          = c;
        addr         = a;
        wr_buf       = wb;
        hs_before    = addr_hs;
        valid_before = valid_cycles;
        start        = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
        @(cmd_checked);
        test_count++;
        $display("test %0d %s: %s", test_count, name, (errors == errors_before) ? "pass" : "fail");
    endtask

    initial begin
        #(WATCHDOG_T);
        $display("Run hung, no command finished within %0d time units", WATCHDOG_T);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        cmd_t        c;
        logic [31:0] a;
        int          w;
        cmd_t        wr_cmds[$];
        logic [31:0] wr_addrs[$];
        seed       = SEED_INIT;
        checks     = 0;
        errors     = 0;
        test_count = 0;
        rst        = 1'b1;
        cmd        = '0;
        addr       = '0;
        wr_buf     = '0;
        start      = 1'b0;
        err_mode   = 1'b0;
        stuck_mode = 1'b0;
        for (int i = 0; i < 1024; i++) shadow[i] = 8'(i * 7) ^ 8'(i >> 8);
        repeat (4) @(posedge clk);
        #10 rst = 1'b0;

        for (int n = 0; n < 6; n++) begin
            c = make_cmd(1'b0, 1'b1, rand_below(3), rand_below(16));
            w = 1 << c.size;
            a = 32'(rand_below(1024)) & ~32'(w - 1);   // Aligned start
            wr_cmds.push_back(c);
            wr_addrs.push_back(a);
            run_cmd("inc_write", c, a, MODE_NORMAL);
        end
        for (int n = 0; n < 6; n++) begin
            c    = wr_cmds[n];
            c.rw = 1'b1;
            run_cmd("inc_read", c, wr_addrs[n], MODE_NORMAL);
        end

        run_cmd("fixed_write_word", make_cmd(1'b0, 1'b0, 2, 5), 32'h200, MODE_NORMAL);
        run_cmd("fixed_read_word", make_cmd(1'b1, 1'b0, 2, 5), 32'h200, MODE_NORMAL);
        run_cmd("fixed_write_half", make_cmd(1'b0, 1'b0, 1, 7), 32'h16a, MODE_NORMAL);
        run_cmd("fixed_read_byte", make_cmd(1'b1, 1'b0, 0, 9), 32'h16b, MODE_NORMAL);

        run_cmd("misaligned_half", make_cmd(1'b0, 1'b1, 1, 3), 32'h101, MODE_NORMAL);
        run_cmd("misaligned_word", make_cmd(1'b1, 1'b1, 2, 2), 32'h102, MODE_NORMAL);
        run_cmd("bad_size", make_cmd(1'b1, 1'b1, 3, 0), 32'h100, MODE_NORMAL);

        run_cmd("slverr_write", make_cmd(1'b0, 1'b1, 2, 3), 32'h300, MODE_ERR);
        run_cmd("slverr_read", make_cmd(1'b1, 1'b1, 2, 3), 32'h300, MODE_ERR);

        run_cmd("stuck_write", make_cmd(1'b0, 1'b1, 0, 0), 32'h050, MODE_STUCK);
        run_cmd("after_stuck_read", make_cmd(1'b1, 1'b1, 2, 1), 32'h300, MODE_NORMAL);

        $display("tests %0d  checks %0d  errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/axi_lite_slave_model.sv
`include "bridge_consts.svh"

module axi_lite_slave_model
    import axi_lite_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     err_mode,     // SLVERR on every response
    input  logic     stuck_mode,   // No ready or response ever rises
    input  axi_req_t axi_req,
    output axi_rsp_t axi_rsp,
    output int       addr_hs       // AW plus AR handshakes
);

    logic [7:0] mem [0:1023];
    logic [9:0] waddr;
    logic [9:0] raddr;
    logic       b_pend;
    logic       r_pend;
    logic [1:0] stall;
    logic [1:0] resp;
    logic       need;
    integer     seed;

    initial begin
        seed = SEED;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'(i * 7) ^ 8'(i >> 8);   // Depends on all ten address bits
        end
    end

    assign resp = err_mode ? 2'b10 : `AXI_RESP_OKAY;

    // Something the slave still owes the master
    assign need = (axi_req.awvalid && !axi_rsp.awready) ||
                  (axi_req.wvalid && !axi_rsp.wready) ||
                  (axi_req.arvalid && !axi_rsp.arready) ||
                  (b_pend && !axi_rsp.bvalid) ||
                  (r_pend && !axi_rsp.rvalid);

    always @(posedge clk) begin
        if (rst) begin
            axi_rsp <= '0;
            b_pend  <= 1'b0;
            r_pend  <= 1'b0;
            stall   <= 2'd0;
            addr_hs <= 0;
        end else begin
            axi_rsp.awready <= 1'b0;   // Ready is a one-cycle pulse
            axi_rsp.wready  <= 1'b0;
            axi_rsp.arready <= 1'b0;
            if (axi_req.awvalid && axi_rsp.awready) begin
                waddr   <= axi_req.awaddr[9:0];
                addr_hs <= addr_hs + 1;
            end
            if (axi_req.wvalid && axi_rsp.wready) begin
                for (int j = 0; j < 4; j++) begin
                    if (axi_req.wstrb[j]) mem[{waddr[9:2], 2'(j)}] <= axi_req.wdata[j*8 +: 8];
                end
                b_pend <= 1'b1;
            end
            if (axi_req.bready && axi_rsp.bvalid) begin
                axi_rsp.bvalid <= 1'b0;
                b_pend         <= 1'b0;
            end
            if (axi_req.arvalid && axi_rsp.arready) begin
                raddr   <= axi_req.araddr[9:0];
                addr_hs <= addr_hs + 1;
                r_pend  <= 1'b1;
            end
            if (axi_req.rready && axi_rsp.rvalid) begin
                axi_rsp.rvalid <= 1'b0;
                r_pend         <= 1'b0;
            end
            if (need && !stuck_mode) begin
                if (stall != 2'd0) begin
                    stall <= stall - 2'd1;
                end else begin
                    stall <= 2'($random(seed));   // Next wait, 0 to 3 cycles
                    if (axi_req.awvalid) begin
                        axi_rsp.awready <= 1'b1;
                    end else if (axi_req.wvalid) begin
                        axi_rsp.wready <= 1'b1;
                    end else if (axi_req.arvalid) begin
                        axi_rsp.arready <= 1'b1;
                    end else if (b_pend) begin
                        axi_rsp.bvalid <= 1'b1;
                        axi_rsp.bresp  <= resp;
                    end else begin
                        axi_rsp.rvalid <= 1'b1;
                        axi_rsp.rresp  <= resp;
                        axi_rsp.rdata  <= {mem[{raddr[9:2], 2'd3}], mem[{raddr[9:2], 2'd2}],
                                           mem[{raddr[9:2], 2'd1}], mem[{raddr[9:2], 2'd0}]};
                    end
                end
            end
        end
    end

endmodule

//--- hdl/axi_lite_master.sv
`include "bridge_consts.svh"

module axi_lite_master
    import axi_lite_pkg::*;
    import bridge_cmd_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  cmd_t                        cmd,
    input  logic [`BRIDGE_ADDR_W-1:0]   addr,
    input  byte_buf_t                   wr_buf,
    input  logic                        start,
    output logic                        done,
    output status_t                     status,
    output byte_buf_t                   rd_buf,
    output logic [`BRIDGE_BUF_IDX_W:0]  rd_count,
    output axi_req_t                    axi_req,
    input  axi_rsp_t                    axi_rsp
);

    xfer_t     job;
    logic      job_valid;
    logic      busy;
    rd_beat_t  rd_beat;
    logic      rd_beat_valid;
    logic      cmd_start;

    // Stage 1, command capture and alignment check
    cmd_decode decode0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .cmd       (cmd),
        .addr      (addr),
        .job       (job),
        .job_valid (job_valid)
    );

    // Stage 2, AXI channel sequencing
    beat_engine engine0 (
        .clk           (clk),
        .rst           (rst),
        .job           (job),
        .job_valid     (job_valid),
        .wr_buf        (wr_buf),
        .axi_req       (axi_req),
        .axi_rsp       (axi_rsp),
        .busy          (busy),
        .done          (done),
        .status        (status),
        .rd_beat       (rd_beat),
        .rd_beat_valid (rd_beat_valid),
        .cmd_start     (cmd_start)
    );

    // Stage 3, read data collection
    read_assembler assembler0 (
        .clk           (clk),
        .rst           (rst),
        .cmd_start     (cmd_start),
        .rd_beat       (rd_beat),
        .rd_beat_valid (rd_beat_valid),
        .rd_buf        (rd_buf),
        .rd_count      (rd_count)
    );

endmodule

//--- hdl/read_assembler.sv
`include "bridge_consts.svh"

module read_assembler
    import bridge_cmd_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_start,
    input  rd_beat_t                    rd_beat,
    input  logic                        rd_beat_valid,
    output byte_buf_t                   rd_buf,
    output logic [`BRIDGE_BUF_IDX_W:0]  rd_count
);

    localparam int CNT_W = `BRIDGE_BUF_IDX_W + 1;

    logic [2:0]       width;
    logic [3:0][7:0]  beat_bytes;   // Beat bytes in address order

    assign width = size_to_width(rd_beat.size);

    // Rotate rdata so the addressed lane comes first
    always_comb begin
        logic [1:0] lane;
        for (int k = 0; k < 4; k++) begin
            lane = rd_beat.addr_lo + 2'(k);
            beat_bytes[k] = rd_beat.rdata[lane*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            rd_buf <= '0;
        end else if (rd_beat_valid) begin
            for (int k = 0; k < 4; k++) begin
                if (k < width) rd_buf[rd_beat.idx + `BRIDGE_BUF_IDX_W'(k)] <= beat_bytes[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_count <= '0;
        end else if (cmd_start) begin
            rd_count <= '0;
        end else if (rd_beat_valid) begin
            rd_count <= CNT_W'(rd_beat.idx) + CNT_W'(width);   // Last beat leaves the total
        end
    end

    // Engine stepping must keep every beat inside the buffer
    a_in_buffer: assert property (
        @(posedge clk) disable iff (rst)
        rd_beat_valid |-> (rd_beat.idx + width) <= `BRIDGE_BUF_BYTES
    );

endmodule

//--- hdl/beat_engine.sv
`include "bridge_consts.svh"

module beat_engine
    import axi_lite_pkg::*;
    import bridge_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  xfer_t     job,
    input  logic      job_valid,
    input  byte_buf_t wr_buf,
    output axi_req_t  axi_req,
    input  axi_rsp_t  axi_rsp,
    output logic      busy,
    output logic      done,
    output status_t   status,
    output rd_beat_t  rd_beat,
    output logic      rd_beat_valid,
    output logic      cmd_start
);

    localparam int WAIT_W = $clog2(`BRIDGE_AXI_TIMEOUT + 1);

    typedef enum logic [3:0] {
        st_idle, st_check,
        st_wr_addr, st_wr_data, st_wr_resp,
        st_rd_addr, st_rd_data,
        st_next, st_finish
    } state_t;

    state_t                        state, state_nxt;
    xfer_t                         job_q;
    logic [`BRIDGE_ADDR_W-1:0]     cur_addr;
    logic [3:0]                    beat_cnt;
    logic [`BRIDGE_BUF_IDX_W-1:0]  byte_idx;
    logic [WAIT_W-1:0]             wait_cnt;
    status_t                       status_q;
    logic                          in_bus, timed_out, last_beat, any_hs;
    logic                          aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic [`BRIDGE_DATA_W-1:0]     wdata;
    logic [`BRIDGE_DATA_W/8-1:0]   wstrb;

    assign in_bus    = state inside {st_wr_addr, st_wr_data, st_wr_resp, st_rd_addr, st_rd_data};
    assign timed_out = (wait_cnt >= `BRIDGE_AXI_TIMEOUT);
    assign last_beat = (beat_cnt == job_q.cmd.len);

    assign aw_hs  = axi_req.awvalid && axi_rsp.awready;
    assign w_hs   = axi_req.wvalid  && axi_rsp.wready;
    assign b_hs   = axi_req.bready  && axi_rsp.bvalid;
    assign ar_hs  = axi_req.arvalid && axi_rsp.arready;
    assign r_hs   = axi_req.rready  && axi_rsp.rvalid;
    assign any_hs = aw_hs | w_hs | b_hs | ar_hs | r_hs;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (job_valid) state_nxt = st_check;
            st_check: begin
                if (job_q.bad_addr)   state_nxt = st_finish;   // No bus activity at all
                else if (job_q.cmd.rw) state_nxt = st_rd_addr;
                else                   state_nxt = st_wr_addr;
            end
            st_wr_addr: if (aw_hs) state_nxt = st_wr_data; else if (timed_out) state_nxt = st_finish;
            st_wr_data: if (w_hs)  state_nxt = st_wr_resp; else if (timed_out) state_nxt = st_finish;
            st_wr_resp: if (b_hs)  state_nxt = st_next;    else if (timed_out) state_nxt = st_finish;
            st_rd_addr: if (ar_hs) state_nxt = st_rd_data; else if (timed_out) state_nxt = st_finish;
            st_rd_data: if (r_hs)  state_nxt = st_next;    else if (timed_out) state_nxt = st_finish;
            st_next: begin
                if (last_beat)         state_nxt = st_finish;
                else if (job_q.cmd.rw) state_nxt = st_rd_addr;
                else                   state_nxt = st_wr_addr;
            end
            st_finish:  state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
            byte_idx <= '0;
            wait_cnt <= '0;
            status_q <= status_ok;
        end else begin
            state <= state_nxt;
            if (in_bus && !timed_out) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else if (!in_bus) begin
                wait_cnt <= '0;   // Fresh budget for every beat
            end
            if (cmd_start) begin
                beat_cnt <= '0;
                byte_idx <= '0;
                status_q <= status_ok;
            end
            if (state == st_check && job_q.bad_addr) status_q <= status_addr_align;
            if ((b_hs && axi_rsp.bresp != `AXI_RESP_OKAY) ||
                (r_hs && axi_rsp.rresp != `AXI_RESP_OKAY)) begin
                status_q <= status_slverr;   // Sticky, later beats keep running
            end
            if (in_bus && timed_out && !any_hs) status_q <= status_timeout;
            if (state == st_next && !last_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                byte_idx <= byte_idx + job_q.width;
            end
        end
    end

    // Job and address registers
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            job_q    <= job;
            cur_addr <= job.addr;
        end else if (state == st_next && !last_beat && job_q.cmd.inc) begin
            cur_addr <= cur_addr + job_q.width;
        end
    end

    // Write bytes go to the lanes picked by the low address bits
    always_comb begin
        logic [1:0] lane;
        wdata = '0;
        for (int k = 0; k < 4; k++) begin
            lane = cur_addr[1:0] + 2'(k);
            if (k < job_q.width) begin
                wdata[lane*8 +: 8] = wr_buf[byte_idx + `BRIDGE_BUF_IDX_W'(k)];
            end
        end
        case (job_q.width)
            3'd1:    wstrb = 4'b0001 << cur_addr[1:0];
            3'd2:    wstrb = 4'b0011 << cur_addr[1:0];
            3'd4:    wstrb = 4'b1111;
            default: wstrb = 4'b0000;
        endcase
    end

    always_comb begin
        axi_req         = '0;
        axi_req.awvalid = (state == st_wr_addr);
        axi_req.awaddr  = cur_addr;
        axi_req.awprot  = 3'b000;   // Unprivileged, secure, data
        axi_req.wvalid  = (state == st_wr_data);
        axi_req.wdata   = wdata;
        axi_req.wstrb   = wstrb;
        axi_req.bready  = (state == st_wr_resp);
        axi_req.arvalid = (state == st_rd_addr);
        axi_req.araddr  = cur_addr;
        axi_req.arprot  = 3'b000;
        axi_req.rready  = (state == st_rd_data);
    end

    assign rd_beat.rdata   = axi_rsp.rdata;
    assign rd_beat.addr_lo = cur_addr[1:0];
    assign rd_beat.size    = job_q.cmd.size;
    assign rd_beat.idx     = byte_idx;
    assign rd_beat_valid   = r_hs;

    assign cmd_start = (state == st_idle) && job_valid;
    assign busy      = (state != st_idle);
    assign done      = (state == st_finish);
    assign status    = status_q;

    a_one_channel: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({axi_req.awvalid, axi_req.wvalid, axi_req.bready,
                  axi_req.arvalid, axi_req.rready})
    );

    // AW must not be withdrawn before the slave takes it
    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        (axi_req.awvalid && !axi_rsp.awready && !timed_out) |=> axi_req.awvalid
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

endmodule

//--- hdl/cmd_decode.sv
`include "bridge_consts.svh"

module cmd_decode
    import bridge_cmd_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      busy,
    input  cmd_t                      cmd,
    input  logic [`BRIDGE_ADDR_W-1:0] addr,
    output xfer_t                     job,
    output logic                      job_valid
);

    logic accept;

    // Start alignment check on the low address bits
    function automatic logic addr_bad(input logic [1:0] size, input logic [1:0] lo);
        case (size)
            2'd0:    return 1'b0;
            2'd1:    return lo[0];        // Halfword needs an even address
            2'd2:    return |lo;          // Word needs a word address
            default: return 1'b1;         // Size code 3 is never valid
        endcase
    endfunction

    // Engine still idle during the job_valid cycle, so block that one too
    assign accept = start && !busy && !job_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
        end
    end

    // Job payload, only meaningful with job_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            job.cmd      <= cmd;
            job.addr     <= addr;
            job.width    <= size_to_width(cmd.size);
            job.bad_addr <= addr_bad(cmd.size, addr[1:0]);
        end
    end

    // A new job must never overlap a running command
    a_no_job_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        job_valid |-> !busy
    );

endmodule

//--- hdl/bridge_cmd_pkg.sv
`include "bridge_consts.svh"

package bridge_cmd_pkg;

    // Command byte, rw in bit 7
    typedef struct packed {
        logic       rw;     // 1 = read
        logic       inc;    // 1 = incrementing address
        logic [1:0] size;   // 0/1/2 = 1/2/4 bytes
        logic [3:0] len;    // Beats minus one
    } cmd_t;

    typedef enum logic [7:0] {
        status_ok         = 8'h00,
        status_addr_align = 8'h03,
        status_timeout    = 8'h04,
        status_slverr     = 8'h05
    } status_t;

    // Job handed from decode to the engine
    typedef struct packed {
        cmd_t                       cmd;
        logic [`BRIDGE_ADDR_W-1:0]  addr;
        logic                       bad_addr;
        logic [2:0]                 width;     // Bytes per beat
    } xfer_t;

    // One accepted read beat
    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0]    rdata;
        logic [1:0]                   addr_lo;
        logic [1:0]                   size;
        logic [`BRIDGE_BUF_IDX_W-1:0] idx;
    } rd_beat_t;

    typedef logic [`BRIDGE_BUF_BYTES-1:0][7:0] byte_buf_t;

    // Size field to bytes, 0 for the invalid code
    function automatic logic [2:0] size_to_width(input logic [1:0] size);
        case (size)
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            2'd2:    return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

endpackage

//--- hdl/axi_lite_pkg.sv
`include "bridge_consts.svh"

package axi_lite_pkg;

    // Master driven side of the bus
    typedef struct packed {
        logic                         awvalid;
        logic [`BRIDGE_ADDR_W-1:0]    awaddr;
        logic [2:0]                   awprot;
        logic                         wvalid;
        logic [`BRIDGE_DATA_W-1:0]    wdata;
        logic [`BRIDGE_DATA_W/8-1:0]  wstrb;
        logic                         bready;
        logic                         arvalid;
        logic [`BRIDGE_ADDR_W-1:0]    araddr;
        logic [2:0]                   arprot;
        logic                         rready;
    } axi_req_t;

    // Slave driven side of the bus
    typedef struct packed {
        logic                         awready;
        logic                         wready;
        logic                         bvalid;
        logic [1:0]                   bresp;
        logic                         arready;
        logic                         rvalid;
        logic [`BRIDGE_DATA_W-1:0]    rdata;
        logic [1:0]                   rresp;
    } axi_rsp_t;

endpackage

//--- hdl/bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// Bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// Byte buffer shared by write and read data
`define BRIDGE_BUF_BYTES 64
`define BRIDGE_BUF_IDX_W 6   // log2 of buffer depth

// Wait cycles allowed per beat before giving up
`define BRIDGE_AXI_TIMEOUT 2500

// AXI response codes
`define AXI_RESP_OKAY 2'b00

`endif
